// ==== filelist.f ====
src/core_bus_pkg.sv
src/core_isa_pkg.sv
src/core_regfile.sv
src/core_fetch.sv
src/core_exec.sv
src/core_lsu.sv
src/core_top.sv
tb/core_tb_sva.sv
tb/core_tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 -f filelist.f --top-module core_tb_top -o core_tb
out=$(./obj_dir/core_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== src/core_bus_pkg.sv ====
// ================================================
// Bus address, data and byte-enable types, boot
// address and fetch buffer limits
// ================================================
package core_bus_pkg;

  // Byte address, used on both buses and for the PC
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  localparam addr_t BOOT_ADDR = 32'h0000_0000;

  // Prefetch buffer depth, also the cap on fetches in flight
  localparam int FETCH_DEPTH = 2;

  // Counters hold 0..FETCH_DEPTH, pointers index the buffer
  typedef logic [$clog2(FETCH_DEPTH+1)-1:0] fetch_cnt_t;
  typedef logic [$clog2(FETCH_DEPTH)-1:0]   fetch_ptr_t;

endpackage

// ==== src/core_exec.sv ====
// ================================================
// Decode and execute stage, ALU, load/store
// hand-off to the LSU and halt on ECALL
// ================================================
module core_exec
  import core_bus_pkg::*;
  import core_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      instr_valid_i,
  input  word_t     instr_word_i,
  input  addr_t     instr_pc_i,
  output logic      instr_take_o,
  output logic      halt_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output word_t     rf_wdata_o,
  output logic      lsu_start_o,
  output logic      lsu_we_o,
  output addr_t     lsu_addr_o,
  output word_t     lsu_wdata_o,
  input  logic      lsu_done_i,
  input  word_t     lsu_rdata_i
);

  exec_state_e state_q;
  exec_state_e state_d;
  opcode_t     opcode;
  funct3_t     funct3;
  funct7_t     funct7;
  reg_addr_t   rd;
  reg_addr_t   ld_rd_q;
  word_t       imm_i;
  word_t       imm_s;
  word_t       alu_b;
  word_t       alu_res;
  alu_op_e     alu_op;
  logic        exec_ok;
  logic        is_op;
  logic        is_op_imm;
  logic        is_load;
  logic        is_store;
  logic        is_ecall;
  logic        ld_q;
  logic        ld_wb;

  // Field extraction, RV32E register indices are four bits
  assign opcode       = opcode_t'(instr_word_i[6:0]);
  assign rd           = instr_word_i[10:7];
  assign funct3       = instr_word_i[14:12];
  assign funct7       = instr_word_i[31:25];
  assign rf_raddr_a_o = instr_word_i[18:15];
  assign rf_raddr_b_o = instr_word_i[23:20];

  assign imm_i = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
  assign imm_s = {{20{instr_word_i[31]}}, instr_word_i[31:25], instr_word_i[11:7]};

  // One word per cycle while running
  assign instr_take_o = (state_q == EX_RUN) && instr_valid_i;
  // A misaligned fetch address executes as a no-op
  assign exec_ok      = instr_take_o && (instr_pc_i[1:0] == 2'b00);

  assign is_op     = exec_ok && (opcode == OPC_OP) && (funct3 == FUNCT3_ADD);
  assign is_op_imm = exec_ok && (opcode == OPC_OP_IMM) && (funct3 == FUNCT3_ADD);
  assign is_load   = exec_ok && (opcode == OPC_LOAD) && (funct3 == FUNCT3_WORD);
  assign is_store  = exec_ok && (opcode == OPC_STORE) && (funct3 == FUNCT3_WORD);
  assign is_ecall  = exec_ok && (opcode == OPC_SYSTEM);

  // Shared adder also forms load and store addresses
  assign alu_op = (is_op && (funct7 == FUNCT7_SUB)) ? ALU_SUB : ALU_ADD;

  always_comb begin
    if (is_op) begin
      alu_b = rf_rdata_b_i;
    end else if (is_store) begin
      alu_b = imm_s;
    end else begin
      alu_b = imm_i;
    end
  end

  assign alu_res = (alu_op == ALU_SUB) ? (rf_rdata_a_i - alu_b) : (rf_rdata_a_i + alu_b);

  assign lsu_start_o = is_load || is_store;
  assign lsu_we_o    = is_store;
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = rf_rdata_b_i;

  // Load data is written at the edge it returns
  assign ld_wb      = (state_q == EX_WAIT_MEM) && lsu_done_i && ld_q;
  assign rf_we_o    = is_op || is_op_imm || ld_wb;
  assign rf_waddr_o = ld_wb ? ld_rd_q : rd;
  assign rf_wdata_o = ld_wb ? lsu_rdata_i : alu_res;

  assign halt_o = (state_q == EX_HALT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      EX_RUN: begin
        if (lsu_start_o) begin
          state_d = EX_WAIT_MEM;
        end else if (is_ecall) begin
          state_d = EX_HALT;
        end
      end
      EX_WAIT_MEM: begin
        if (lsu_done_i) begin
          state_d = EX_RUN;
        end
      end
      default: state_d = EX_HALT;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= EX_RUN;
      ld_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (lsu_start_o) begin
        ld_q <= is_load;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_load) begin
      ld_rd_q <= rd;
    end
  end

endmodule

// ==== src/core_fetch.sv ====
// ================================================
// Fetch stage with instruction bus requests and a
// small in-order prefetch buffer
// ================================================
module core_fetch
  import core_bus_pkg::*;
  import core_isa_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  fetch_enable_i,
  input  logic  halt_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  output logic  instr_valid_o,
  output word_t instr_word_o,
  output addr_t instr_pc_o,
  input  logic  instr_take_i,
  output logic  idle_o
);

  addr_t      pc_q;
  addr_t      take_pc_q;
  fetch_cnt_t out_cnt_q;
  fetch_cnt_t buf_cnt_q;
  fetch_ptr_t wr_ptr_q;
  fetch_ptr_t rd_ptr_q;
  word_t      buf_q [FETCH_DEPTH];
  logic       en_q;
  logic       stop_q;
  logic       pend_q;
  logic       can_issue;
  logic       grant;
  logic       take;
  logic       ecall_seen;

  // Granted requests reserve a slot until their word is consumed
  assign can_issue = en_q && !stop_q && !halt_i &&
                     ((out_cnt_q + buf_cnt_q) < fetch_cnt_t'(FETCH_DEPTH));

  // A raised request is kept until the memory grants it
  assign instr_req_o  = can_issue || pend_q;
  assign instr_addr_o = pc_q;
  assign grant        = instr_req_o && instr_gnt_i;

  assign instr_valid_o = (buf_cnt_q != '0);
  assign instr_word_o  = buf_q[rd_ptr_q];
  assign instr_pc_o    = take_pc_q;
  assign take          = instr_take_i && instr_valid_o;

  // No point prefetching past an ECALL
  assign ecall_seen = instr_rvalid_i && (opcode_t'(instr_rdata_i[6:0]) == OPC_SYSTEM);

  assign idle_o = (out_cnt_q == '0) && !instr_req_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q      <= 1'b0;
      stop_q    <= 1'b0;
      pend_q    <= 1'b0;
      pc_q      <= BOOT_ADDR;
      take_pc_q <= BOOT_ADDR;
      out_cnt_q <= '0;
      buf_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      en_q   <= fetch_enable_i;
      pend_q <= instr_req_o && !instr_gnt_i;
      if (halt_i || ecall_seen) begin
        stop_q <= 1'b1;
      end
      if (grant) begin
        pc_q <= pc_q + 32'd4;
      end
      if (take) begin
        take_pc_q <= take_pc_q + 32'd4;
        rd_ptr_q  <= rd_ptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      out_cnt_q <= out_cnt_q + fetch_cnt_t'(grant) - fetch_cnt_t'(instr_rvalid_i);
      buf_cnt_q <= buf_cnt_q + fetch_cnt_t'(instr_rvalid_i) - fetch_cnt_t'(take);
    end
  end

  // Returned words land in arrival order
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      buf_q[wr_ptr_q] <= instr_rdata_i;
    end
  end

endmodule

// ==== src/core_isa_pkg.sv ====
// ================================================
// RV32E subset encodings, instruction field types,
// ALU operations and execute FSM states
// ================================================
package core_isa_pkg;

  // Sixteen architectural registers
  typedef logic [3:0] reg_addr_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam funct3_t FUNCT3_ADD  = 3'b000;
  localparam funct3_t FUNCT3_WORD = 3'b010;

  // Selects SUB over ADD for register-register ops
  localparam funct7_t FUNCT7_SUB = 7'b0100000;

  typedef enum logic {ALU_ADD, ALU_SUB} alu_op_e;

  typedef enum logic [1:0] {EX_RUN, EX_WAIT_MEM, EX_HALT} exec_state_e;

endpackage

// ==== src/core_lsu.sv ====
// ================================================
// Load-store unit driving the data bus, one word
// access in flight
// ================================================
module core_lsu
  import core_bus_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  lsu_start_i,
  input  logic  lsu_we_i,
  input  addr_t lsu_addr_i,
  input  word_t lsu_wdata_i,
  output logic  lsu_done_o,
  output word_t lsu_rdata_o,
  output logic  data_req_o,
  output addr_t data_addr_o,
  output logic  data_we_o,
  output be_t   data_be_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  word_t data_rdata_i
);

  logic  req_q;
  logic  wait_q;
  logic  idle;
  logic  we_q;
  addr_t addr_q;
  word_t wdata_q;

  assign idle = !req_q && !wait_q;

  // Request waits for grant, then the access waits for rvalid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (idle && lsu_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (idle && lsu_start_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign data_req_o   = req_q;
  assign data_addr_o  = addr_q;
  assign data_we_o    = we_q;
  assign data_wdata_o = wdata_q;
  // Word accesses only
  assign data_be_o    = '1;

  assign lsu_done_o  = data_rvalid_i;
  assign lsu_rdata_o = data_rdata_i;

endmodule

// ==== src/core_regfile.sv ====
// ================================================
// Sixteen-entry register file with x0 tied to zero
// ================================================
module core_regfile
  import core_bus_pkg::*;
  import core_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs_q [16];

  // Writes to x0 are dropped so it keeps its reset value
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== src/core_top.sv ====
// ================================================
// Core top level, fetch, execute, register file
// and LSU with sleep indication
// ================================================
module core_top
  import core_bus_pkg::*;
  import core_isa_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  fetch_enable_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  output logic  data_req_o,
  output addr_t data_addr_o,
  output logic  data_we_o,
  output be_t   data_be_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  word_t data_rdata_i,
  output logic  core_sleep_o
);

  logic      instr_valid;
  word_t     instr_word;
  addr_t     instr_pc;
  logic      instr_take;
  logic      halt;
  logic      fetch_idle;
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      lsu_start;
  logic      lsu_we;
  addr_t     lsu_addr;
  word_t     lsu_wdata;
  logic      lsu_done;
  word_t     lsu_rdata;

  core_fetch u_fetch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .halt_i         (halt),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid),
    .instr_word_o   (instr_word),
    .instr_pc_o     (instr_pc),
    .instr_take_i   (instr_take),
    .idle_o         (fetch_idle)
  );

  core_exec u_exec (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid),
    .instr_word_i  (instr_word),
    .instr_pc_i    (instr_pc),
    .instr_take_o  (instr_take),
    .halt_o        (halt),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .lsu_start_o   (lsu_start),
    .lsu_we_o      (lsu_we),
    .lsu_addr_o    (lsu_addr),
    .lsu_wdata_o   (lsu_wdata),
    .lsu_done_i    (lsu_done),
    .lsu_rdata_i   (lsu_rdata)
  );

  core_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  core_lsu u_lsu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lsu_start_i   (lsu_start),
    .lsu_we_i      (lsu_we),
    .lsu_addr_i    (lsu_addr),
    .lsu_wdata_i   (lsu_wdata),
    .lsu_done_o    (lsu_done),
    .lsu_rdata_o   (lsu_rdata),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i)
  );

  // Asleep once halted and the fetch bus has drained
  assign core_sleep_o = halt && fetch_idle;

endmodule

// ==== tb/core_tb_sva.sv ====
// ================================================
// Bus protocol, outstanding limit and sleep checks
// bound to the core top level
// ================================================
module core_tb_sva
  import core_bus_pkg::*;
(
  input logic  clk_i,
  input logic  rst_i,
  input logic  instr_req_o,
  input addr_t instr_addr_o,
  input logic  instr_gnt_i,
  input logic  instr_rvalid_i,
  input logic  data_req_o,
  input addr_t data_addr_o,
  input logic  data_we_o,
  input word_t data_wdata_o,
  input logic  data_gnt_i,
  input logic  data_rvalid_i,
  input logic  core_sleep_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int i_out_q;
  int d_out_q;

  // Granted requests still waiting for rvalid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      i_out_q <= 0;
      d_out_q <= 0;
    end else begin
      i_out_q <= i_out_q + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
      d_out_q <= d_out_q + int'(data_req_o && data_gnt_i) - int'(data_rvalid_i);
    end
  end

  instr_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("Instruction request dropped or changed before grant");

  data_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_wdata_o))
    else $error("Data request dropped or changed before grant");

  instr_rvalid_a: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_rvalid_i |-> i_out_q > 0)
    else $error("Instruction rvalid without an earlier grant");

  data_rvalid_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_rvalid_i |-> d_out_q > 0)
    else $error("Data rvalid without an earlier grant");

  fetch_depth_a: assert property (@(posedge clk_i) disable iff (rst_i)
    i_out_q <= FETCH_DEPTH && d_out_q <= 1)
    else $error("Too many requests in flight");

  reset_quiet_a: assert property (@(posedge clk_i)
    rst_i |=> !instr_req_o && !data_req_o && !core_sleep_o)
    else $error("Request or sleep high right after reset");

  // Sleep is sticky and the buses stay quiet
  sleep_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    core_sleep_o |=> core_sleep_o && !instr_req_o && !data_req_o)
    else $error("Sleep dropped or a request rose while asleep");

endmodule

bind core_top core_tb_sva u_sva (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .instr_req_o    (instr_req_o),
  .instr_addr_o   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .data_req_o     (data_req_o),
  .data_addr_o    (data_addr_o),
  .data_we_o      (data_we_o),
  .data_wdata_o   (data_wdata_o),
  .data_gnt_i     (data_gnt_i),
  .data_rvalid_i  (data_rvalid_i),
  .core_sleep_o   (core_sleep_o)
);

// ==== tb/core_tb_top.sv ====
// ================================================
// Core testbench, bus memories with random delays,
// program generator with reference model, checks
// ================================================
module core_tb_top
  import core_bus_pkg::*;
  import core_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    PROG_LEN     = 40;
  localparam int    TIMEOUT      = PROG_LEN * 12 + 200;
  localparam int    DRAIN_CYCLES = 20;
  localparam addr_t DATA_BASE    = 32'h0000_0400;
  localparam word_t ECALL_WORD   = 32'h0000_0073;
  localparam word_t NOP_WORD     = 32'h0000_0013;

  logic  clk_i = 1'b0;
  logic  rst_i;
  logic  fetch_enable_i;
  logic  instr_req_o;
  addr_t instr_addr_o;
  logic  instr_gnt_i;
  logic  instr_rvalid_i;
  word_t instr_rdata_i;
  logic  data_req_o;
  addr_t data_addr_o;
  logic  data_we_o;
  be_t   data_be_o;
  word_t data_wdata_o;
  logic  data_gnt_i;
  logic  data_rvalid_i;
  word_t data_rdata_i;
  logic  core_sleep_o;

  word_t       prog [PROG_LEN];
  word_t       dmem [16];
  word_t       mdl_regs [16];
  word_t       mdl_mem [16];
  logic [31:0] rng_q = 32'hf255;
  // Expected data accesses in program order
  logic        exp_we [$];
  addr_t       exp_addr [$];
  word_t       exp_data [$];
  string       exp_name [$];
  word_t       iq_word [$];
  int          iq_due [$];
  int          i_gap;
  int          d_gap;
  logic        d_busy;
  int          d_due;
  word_t       d_word;
  addr_t       fetch_addr;
  int          cycle;
  int          n_acc;
  int          n_seen;
  logic        ecall_fetched;
  int          drain;

  core_top uut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .core_sleep_o   (core_sleep_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng_q = xorshift(rng_q);
    return int'(rng_q % n);
  endfunction

  // RISC-V I, R and S formats with register fields padded to five bits
  function automatic word_t enc_i(input opcode_t op, input funct3_t f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
  endfunction

  function automatic word_t enc_r(input funct7_t f7, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, 1'b0, rs2, 1'b0, rs1, FUNCT3_ADD, 1'b0, rd, OPC_OP};
  endfunction

  function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], 1'b0, rs2, 1'b0, rs1, FUNCT3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic void mdl_write(input reg_addr_t rd, input word_t v);
    if (rd != '0) begin
      mdl_regs[rd] = v;
    end
  endfunction

  function automatic void expect_access(input logic we, input addr_t a, input word_t d,
                                        input string name);
    exp_we.push_back(we);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_name.push_back(name);
  endfunction

  // Stores src to a random slot off the x1 base and returns the slot
  function automatic logic [3:0] add_store(input int i, input reg_addr_t src,
                                           input string name);
    logic [3:0] slot;
    word_t      off;
    slot = 4'(rand_below(16));
    off  = word_t'(slot) << 2;
    prog[i] = enc_s(src, 4'd1, off[11:0]);
    mdl_mem[slot] = mdl_regs[src];
    expect_access(1'b1, DATA_BASE + off, mdl_regs[src], name);
    return slot;
  endfunction

  // Generates the program and runs it on the reference model
  task automatic build_program();
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   ld_rd;
    reg_addr_t   dv_rd;
    logic [11:0] imm;
    logic [3:0]  last_slot;
    word_t       off;
    ld_rd = 4'd2;
    dv_rd = 4'd2;
    last_slot = '0;
    for (int k = 0; k < 16; k++) begin
      dmem[k] = 32'hd000_0000 | DATA_BASE | (word_t'(k) << 2);
      mdl_mem[k] = dmem[k];
      mdl_regs[k] = '0;
    end
    // x1 stays the data base for the whole program
    prog[0] = enc_i(OPC_OP_IMM, FUNCT3_ADD, 4'd1, 4'd0, DATA_BASE[11:0]);
    mdl_regs[1] = DATA_BASE;
    for (int i = 1; i < PROG_LEN - 1; i++) begin
      rd  = reg_addr_t'(2 + rand_below(14));
      rs1 = reg_addr_t'(rand_below(16));
      rs2 = reg_addr_t'(rand_below(16));
      imm = 12'(rand_below(4096));
      case ((i - 1) % 9)
        0: begin
          prog[i] = enc_i(OPC_OP_IMM, FUNCT3_ADD, rd, rs1, imm);
          mdl_write(rd, mdl_regs[rs1] + {{20{imm[11]}}, imm});
        end
        1: begin
          prog[i] = enc_r(7'b0, rd, rs1, rs2);
          mdl_write(rd, mdl_regs[rs1] + mdl_regs[rs2]);
        end
        2: begin
          prog[i] = enc_r(FUNCT7_SUB, rd, rs1, rs2);
          mdl_write(rd, mdl_regs[rs1] - mdl_regs[rs2]);
        end
        3: last_slot = add_store(i, rs2, "alu_store");
        4: begin
          off = word_t'(last_slot) << 2;
          prog[i] = enc_i(OPC_LOAD, FUNCT3_WORD, rd, 4'd1, off[11:0]);
          expect_access(1'b0, DATA_BASE + off, '0, "load");
          mdl_write(rd, mdl_mem[last_slot]);
          ld_rd = rd;
        end
        // Uses the loaded register straight away
        5: begin
          prog[i] = enc_r(7'b0, rd, ld_rd, rs2);
          mdl_write(rd, mdl_regs[ld_rd] + mdl_regs[rs2]);
          dv_rd = rd;
        end
        6: void'(add_store(i, dv_rd, "load_derived_store"));
        7: prog[i] = enc_i(OPC_OP_IMM, FUNCT3_ADD, 4'd0, rs1, imm);
        default: void'(add_store(i, 4'd0, "x0_store"));
      endcase
    end
    prog[PROG_LEN - 1] = ECALL_WORD;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input word_t exp, input word_t act);
    assert (act == exp) else begin
      abort_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_idle(input string phase);
    check_val({phase, "_instr_req"}, '0, word_t'(instr_req_o));
    check_val({phase, "_data_req"}, '0, word_t'(data_req_o));
    check_val({phase, "_sleep"}, '0, word_t'(core_sleep_o));
  endtask

  task automatic watch_sleep();
    if (core_sleep_o && !ecall_fetched) begin
      abort_run("core_sleep_o rose before the ECALL was fetched");
    end else if (drain > 0 && !core_sleep_o) begin
      abort_run("core_sleep_o dropped after it had risen");
    end else if (core_sleep_o && data_req_o) begin
      abort_run("Data request seen while the core sleeps");
    end else if (core_sleep_o) begin
      drain++;
    end
  endtask

  // Instruction memory answering in order 1 to 3 cycles after grant
  task automatic serve_instr();
    int due;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (iq_word.size() > 0 && iq_due[0] <= cycle) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = iq_word.pop_front();
      void'(iq_due.pop_front());
      if (instr_rdata_i == ECALL_WORD) begin
        ecall_fetched = 1'b1;
      end
    end
    if (instr_req_o) begin
      if (i_gap < 0) begin
        i_gap = rand_below(4);
      end
      if (i_gap == 0) begin
        instr_gnt_i = 1'b1;
        check_val("fetch_addr", fetch_addr, instr_addr_o);
        if (instr_addr_o < addr_t'(PROG_LEN * 4)) begin
          iq_word.push_back(prog[instr_addr_o[7:2]]);
        end else begin
          iq_word.push_back(NOP_WORD);
        end
        due = cycle + 1 + rand_below(3);
        if (iq_due.size() > 0 && due <= iq_due[$]) begin
          due = iq_due[$] + 1;
        end
        iq_due.push_back(due);
        fetch_addr = fetch_addr + 32'd4;
      end
      i_gap--;
    end
  endtask

  // Compares a granted data access with the next model access
  task automatic grant_data();
    string name;
    if (exp_we.size() == 0) begin
      abort_run("Data request seen after the last expected access");
    end else begin
      name = exp_name.pop_front();
      check_val({name, "_we"}, word_t'(exp_we.pop_front()), word_t'(data_we_o));
      check_val({name, "_addr"}, exp_addr.pop_front(), data_addr_o);
      check_val({name, "_be"}, 32'hf, word_t'(data_be_o));
      if (data_we_o) begin
        check_val({name, "_data"}, exp_data[0], data_wdata_o);
        dmem[data_addr_o[5:2]] = data_wdata_o;
      end
      void'(exp_data.pop_front());
      d_word = dmem[data_addr_o[5:2]];
      d_busy = 1'b1;
      d_due  = cycle + 1 + rand_below(3);
      n_seen++;
    end
  endtask

  task automatic serve_data();
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    if (d_busy && d_due <= cycle) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = d_word;
      d_busy = 1'b0;
    end
    if (data_req_o) begin
      if (d_gap < 0) begin
        d_gap = rand_below(4);
      end
      if (d_gap == 0) begin
        data_gnt_i = 1'b1;
        grant_data();
      end
      d_gap--;
    end
  endtask

  initial begin
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    i_gap          = -1;
    d_gap          = -1;
    d_busy         = 1'b0;
    fetch_addr     = BOOT_ADDR;
    cycle          = 0;
    n_seen         = 0;
    ecall_fetched  = 1'b0;
    drain          = 0;
    build_program();
    n_acc = exp_we.size();
    repeat (16) begin
      @(posedge clk_i);
      #1;
      check_idle("reset");
    end
    rst_i = 1'b0;
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_idle("fetch_disabled");
    end
    fetch_enable_i = 1'b1;
    while (drain < DRAIN_CYCLES) begin
      @(posedge clk_i);
      #1;
      cycle++;
      if (cycle > TIMEOUT) begin
        abort_run($sformatf("Timeout, core did not go to sleep within %0d cycles", TIMEOUT));
      end
      watch_sleep();
      serve_instr();
      serve_data();
    end
    if (n_seen != n_acc) begin
      abort_run($sformatf("ERR access_count expected %0d actual %0d", n_acc, n_seen));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
